//--- rtl/homeDisplay_defs.svh
`ifndef HOME_DISPLAY_DEFS_SVH
`define HOME_DISPLAY_DEFS_SVH

`define SCREEN_WIDTH  160 // pixels per row
`define SCREEN_HEIGHT 120 // rows
`define X_BITS        8
`define Y_BITS        7
`define COLOUR_BITS   3   // one bit each for r, g, b

`define TILE_SIDE     4   // tiles are square
`define TILE_X_BASE   16  // x origin of room 0
`define TILE_X_STEP   28  // x distance between neighbouring rooms
`define TILE_Y_LIGHT  40  // light tiles sit in the upper band
`define TILE_Y_DOOR   72  // door tiles sit in the lower band
`define ROOM_COUNT    5

`define ADDR_BITS     16
`define CMD_ADDR      16'h0000
`define STATUS_ADDR   16'h0004 // bit 0 is busy

`endif

//--- rtl/displayPkg.sv
`default_nettype none

`include "homeDisplay_defs.svh"

package displayPkg;

	typedef logic [`X_BITS-1:0] xCoord; // 0 to 159
	typedef logic [`Y_BITS-1:0] yCoord; // 0 to 119

	// linear pixel address, y times the row length plus x
	typedef logic [$clog2(`SCREEN_WIDTH * `SCREEN_HEIGHT)-1:0] pixelIndex;

	typedef enum logic [`COLOUR_BITS-1:0] {
		BLACK  = 3'd0, // cleared screen
		YELLOW = 3'd6, // light or door on
		WHITE  = 3'd7  // light or door off
	} colourT;

	typedef enum logic [1:0] {
		IDLE, // waiting for a start pulse
		RUN,  // requesting pixel writes
		DONE  // one cycle, drives the done pulse
	} engineState;

endpackage

`default_nettype wire

//--- rtl/controlPkg.sv
`default_nettype none

package controlPkg;

	typedef enum logic [1:0] {
		NOP          = 2'd0, // rejected with an error
		DRAW_TILE    = 2'd1,
		CLEAR_SCREEN = 2'd2  // 3 is undefined and rejected too
	} opcodeT;

	typedef logic [2:0] roomT; // only 0 to 4 are real rooms

	typedef enum logic {
		DOOR  = 1'b0,
		LIGHT = 1'b1
	} functionT;

	// layout of a word written to the command register
	typedef struct packed {
		logic [31:10] unused;
		opcodeT       opcode;   // bits 9:8
		logic [7:5]   reserved;
		logic         on;       // bit 4, yellow when set
		functionT     func;     // bit 3
		roomT         room;     // bits 2:0
	} commandT;

endpackage

`default_nettype wire

//--- rtl/apbCommandRegs.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module apbCommandRegs
	import displayPkg::*;
	import controlPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`ADDR_BITS-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  drawDone,
	input  logic                  clearDone,
	input  logic                  readGrant,
	input  colourT                readData,
	output logic                  drawStart,
	output logic                  clearStart,
	output logic                  readReq,
	output roomT                  room,
	output functionT              func,
	output logic                  on,
	output xCoord                 readX,
	output yCoord                 readY
);
	commandT command;
	logic    access;     // apb access phase
	logic    cmdWrite;
	logic    statusRead;
	logic    pixelRead;  // any read with the top address bit set
	logic    cmdBad;     // bad opcode or room out of range
	logic    accept;     // command write that completes this cycle
	logic    busy;       // an engine is running
	logic    readDone;   // frame buffer data is on readData

	assign access = psel & penable;
	assign command = commandT'(pwdata);
	assign cmdWrite = pwrite & (paddr == `CMD_ADDR);
	assign statusRead = ~pwrite & (paddr == `STATUS_ADDR);
	assign pixelRead = ~pwrite & paddr[`ADDR_BITS-1];
	assign cmdBad = !(command.opcode inside {DRAW_TILE, CLEAR_SCREEN})
		|| (command.room >= `ROOM_COUNT);
	assign accept = access & cmdWrite & ~busy; // stalls while an engine runs

	assign readReq = access & pixelRead & ~readDone; // held until granted
	assign readX = paddr[`X_BITS-1:0];
	assign readY = paddr[8 +: `Y_BITS];

	always_comb begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		if (access) begin
			if (cmdWrite) begin
				pready = ~busy;
				pslverr = ~busy & cmdBad;
			end else if (statusRead) begin
				pready = 1'b1;
				prdata = {31'b0, busy};
			end else if (pixelRead) begin
				pready = readDone; // one cycle after the grant
				prdata = {{(32 - `COLOUR_BITS){1'b0}}, readData};
			end else begin
				pready = 1'b1; // unmapped address or wrong direction
				pslverr = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			drawStart <= 1'b0;
			clearStart <= 1'b0;
			readDone <= 1'b0;
		end else begin
			drawStart <= accept & ~cmdBad & (command.opcode == DRAW_TILE); // one cycle pulse
			clearStart <= accept & ~cmdBad & (command.opcode == CLEAR_SCREEN);
			if (accept & ~cmdBad)
				busy <= 1'b1;
			else if (drawDone | clearDone)
				busy <= 1'b0;
			readDone <= readGrant | (readDone & ~pready); // drops as the read ends
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin // tile fields for the drawer
			room <= command.room;
			func <= command.func;
			on <= command.on;
		end
	end

endmodule

`default_nettype wire

//--- rtl/tileDrawer.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module tileDrawer
	import displayPkg::*;
	import controlPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     drawStart,
	input  roomT     room,
	input  functionT func,
	input  logic     on,
	input  logic     grant,
	output logic     req,
	output xCoord    x,
	output yCoord    y,
	output colourT   colour,
	output logic     done
);
	engineState state;
	logic [3:0] plotCount;  // low bits step x, high bits step y
	xCoord      originX;    // top left corner of the tile
	yCoord      originY;
	colourT     tileColour;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			plotCount <= '0;
		end else begin
			case (state)
				IDLE: if (drawStart) begin
					state <= RUN;
					plotCount <= '0;
				end
				RUN: if (grant) begin // advance only on a granted write
					plotCount <= plotCount + 4'd1;
					if (plotCount == 4'(`TILE_SIDE * `TILE_SIDE - 1))
						state <= DONE;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// placement rule, rooms spread along x and function picks the band
	always_ff @(posedge clock) begin
		if (state == IDLE && drawStart) begin
			originX <= xCoord'(`TILE_X_BASE + `TILE_X_STEP * room);
			originY <= (func == LIGHT) ? yCoord'(`TILE_Y_LIGHT) : yCoord'(`TILE_Y_DOOR);
			tileColour <= on ? YELLOW : WHITE;
		end
	end

	assign req = (state == RUN);
	assign x = originX + xCoord'(plotCount[1:0]); // row major walk
	assign y = originY + yCoord'(plotCount[3:2]);
	assign colour = tileColour;
	assign done = (state == DONE); // one cycle after the last write

endmodule

`default_nettype wire

//--- rtl/screenClearer.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module screenClearer
	import displayPkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  clearStart,
	input  logic  grant,
	output logic  req,
	output xCoord x,
	output yCoord y,
	output logic  done
);
	engineState state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			x <= '0;
			y <= '0;
		end else begin
			case (state)
				IDLE: if (clearStart) begin
					state <= RUN;
					x <= '0; // sweep starts top left
					y <= '0;
				end
				RUN: if (grant) begin
					if (x == xCoord'(`SCREEN_WIDTH - 1)) begin // end of row
						x <= '0;
						if (y == yCoord'(`SCREEN_HEIGHT - 1))
							state <= DONE; // last pixel written
						else
							y <= y + 1'b1;
					end else
						x <= x + 1'b1;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign req = (state == RUN); // colour is black, supplied by the arbiter
	assign done = (state == DONE);

endmodule

`default_nettype wire

//--- rtl/pixelArbiter.sv
`default_nettype none

module pixelArbiter
	import displayPkg::*;
(
	input  logic   clearReq,
	input  logic   drawReq,
	input  logic   readReq,
	input  xCoord  clearX,
	input  xCoord  drawX,
	input  xCoord  readX,
	input  yCoord  clearY,
	input  yCoord  drawY,
	input  yCoord  readY,
	input  colourT drawColour,
	output logic   clearGrant,
	output logic   drawGrant,
	output logic   readGrant,
	output xCoord  memX,
	output yCoord  memY,
	output colourT memColour,
	output logic   memWrite
);
	// fixed priority, clearer over drawer over reader
	assign clearGrant = clearReq;
	assign drawGrant = drawReq & ~clearReq;
	assign readGrant = readReq & ~clearReq & ~drawReq;
	assign memWrite = clearReq | drawReq; // only the engines write

	always_comb begin
		if (clearReq) begin
			memX = clearX;
			memY = clearY;
			memColour = BLACK; // clearer has no colour of its own
		end else if (drawReq) begin
			memX = drawX;
			memY = drawY;
			memColour = drawColour;
		end else begin
			memX = readX; // idle cycles also present the reader address
			memY = readY;
			memColour = BLACK;
		end
	end

endmodule

`default_nettype wire

//--- rtl/frameBuffer.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module frameBuffer
	import displayPkg::*;
(
	input  logic   clock,
	input  logic   memWrite,
	input  xCoord  memX,
	input  yCoord  memY,
	input  colourT memColour,
	output colourT readData
);
	colourT    pixels [0:`SCREEN_WIDTH * `SCREEN_HEIGHT - 1];
	pixelIndex index;
	logic      inRange; // x past the row end would alias into the next row

	assign index = pixelIndex'(memY * `SCREEN_WIDTH + memX);
	assign inRange = (memX < `SCREEN_WIDTH) && (memY < `SCREEN_HEIGHT);

	// single port, write or read each cycle
	always_ff @(posedge clock) begin
		if (memWrite) begin
			if (inRange)
				pixels[index] <= memColour;
		end else
			readData <= inRange ? pixels[index] : BLACK; // valid the next cycle
	end

endmodule

`default_nettype wire

//--- rtl/homeDisplay.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module homeDisplay
	import displayPkg::*;
	import controlPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`ADDR_BITS-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);
	logic     drawStart;
	logic     clearStart;
	logic     drawDone;
	logic     clearDone;
	roomT     room;
	functionT func;
	logic     on;
	logic     readReq;    // apb pixel reader
	logic     readGrant;
	xCoord    readX;
	yCoord    readY;
	colourT   readData;
	logic     drawReq;    // tile drawer
	logic     drawGrant;
	xCoord    drawX;
	yCoord    drawY;
	colourT   drawColour;
	logic     clearReq;   // screen clearer
	logic     clearGrant;
	xCoord    clearX;
	yCoord    clearY;
	xCoord    memX;       // frame buffer port
	yCoord    memY;
	colourT   memColour;
	logic     memWrite;

	apbCommandRegs regs (
		.clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .drawDone(drawDone), .clearDone(clearDone),
		.readGrant(readGrant), .readData(readData), .drawStart(drawStart),
		.clearStart(clearStart), .readReq(readReq), .room(room), .func(func),
		.on(on), .readX(readX), .readY(readY)
	);

	tileDrawer drawer (
		.clock(clock), .reset(reset), .drawStart(drawStart), .room(room),
		.func(func), .on(on), .grant(drawGrant), .req(drawReq), .x(drawX),
		.y(drawY), .colour(drawColour), .done(drawDone)
	);

	screenClearer clearer (
		.clock(clock), .reset(reset), .clearStart(clearStart), .grant(clearGrant),
		.req(clearReq), .x(clearX), .y(clearY), .done(clearDone)
	);

	pixelArbiter arbiter (
		.clearReq(clearReq), .drawReq(drawReq), .readReq(readReq),
		.clearX(clearX), .drawX(drawX), .readX(readX),
		.clearY(clearY), .drawY(drawY), .readY(readY), .drawColour(drawColour),
		.clearGrant(clearGrant), .drawGrant(drawGrant), .readGrant(readGrant),
		.memX(memX), .memY(memY), .memColour(memColour), .memWrite(memWrite)
	);

	frameBuffer frame (
		.clock(clock), .memWrite(memWrite), .memX(memX), .memY(memY),
		.memColour(memColour), .readData(readData)
	);

endmodule

`default_nettype wire

//--- test/homeDisplay_sva.sv
`default_nettype none

module homeDisplay_sva (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic busy,
	input logic clearReq,
	input logic drawReq,
	input logic readReq,
	input logic clearGrant,
	input logic drawGrant,
	input logic readGrant
);
	// frame buffer port serves one client per cycle
	oneGrant: assert property (@(posedge clock) disable iff (reset)
		$onehot0({clearGrant, drawGrant, readGrant}))
		else $error("more than one arbiter grant high");

	grantNeedsReq: assert property (@(posedge clock) disable iff (reset)
		(clearGrant -> clearReq) && (drawGrant -> drawReq) && (readGrant -> readReq))
		else $error("arbiter grant without its request");

	readyInAccess: assert property (@(posedge clock) disable iff (reset)
		pready |-> (psel && penable)) // only an access phase can end
		else $error("pready high outside an apb access");

	idleAfterReset: assert property (@(posedge clock) reset |=> !busy)
		else $error("busy set right after reset");

endmodule

// the top level is where the registers and the arbiter meet
bind homeDisplay homeDisplay_sva assertions (
	.clock(clock), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
	.busy(regs.busy), .clearReq(clearReq), .drawReq(drawReq), .readReq(readReq),
	.clearGrant(clearGrant), .drawGrant(drawGrant), .readGrant(readGrant)
);

`default_nettype wire

//--- test/homeDisplay_tb.sv
`default_nettype none

`include "homeDisplay_defs.svh"

module homeDisplay_tb
	import displayPkg::*;
	import controlPkg::*;
();
	localparam int PERIOD = 4;
	localparam int PIXELS = `SCREEN_WIDTH * `SCREEN_HEIGHT;
	localparam int READ_CYCLES = 6; // setup, access, grant, data and an idle cycle
	localparam int CLEAR_TEST = PIXELS + 2 + 200 * READ_CYCLES; // sweep plus 200 samples
	localparam int DRAW_TEST = 18 + 36 * READ_CYCLES; // tile plus its 6 by 6 readback
	localparam int LIMIT = 2 * (3 * CLEAR_TEST + 40 * DRAW_TEST) * PERIOD;

	logic                  clock;
	logic                  reset;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`ADDR_BITS-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	colourT model [0:PIXELS-1]; // expected screen
	colourT expQ [$];           // pixel results waiting for the compare process
	colourT actQ [$];
	string  nameQ [$];
	int     errors;

	homeDisplay uut (
		.clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	function automatic colourT expectedPixel(xCoord x, yCoord y);
		return model[int'(y) * `SCREEN_WIDTH + int'(x)];
	endfunction

	function automatic xCoord tileX(roomT r);
		return xCoord'(`TILE_X_BASE + `TILE_X_STEP * int'(r)); // rooms spread along x
	endfunction

	function automatic yCoord tileY(functionT f);
		return (f == LIGHT) ? yCoord'(`TILE_Y_LIGHT) : yCoord'(`TILE_Y_DOOR);
	endfunction

	function automatic logic [31:0] commandWord(opcodeT op, roomT r, functionT f, logic on);
		return {22'b0, op, 3'b0, on, f, r};
	endfunction

	task automatic modelCommand(opcodeT op, roomT r, functionT f, logic on);
		for (int j = 0; j < `TILE_SIDE; j++)
			for (int i = 0; i < `TILE_SIDE; i++)
				if (op == DRAW_TILE)
					model[(tileY(f) + j) * `SCREEN_WIDTH + tileX(r) + i] = on ? YELLOW : WHITE;
		if (op == CLEAR_SCREEN)
			foreach (model[i]) model[i] = BLACK;
	endtask

	task automatic checkColour(string name, colourT expected, colourT actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected %0d got %0d", name, expected, actual);
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected %b got %b", name, expected, actual);
		end
	endtask

	// one apb transfer, outputs sampled on the falling edge
	task automatic apbTransfer(input logic write, input logic [`ADDR_BITS-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err,
		output int stalls);
		@(posedge clock);
		psel <= 1'b1; // setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		stalls = 0;
		@(negedge clock);
		while (!pready) begin // watchdog bounds this wait
			stalls++;
			@(negedge clock);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock); // transfer ends on this edge
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic sendCommand(string name, opcodeT op, roomT r, functionT f, logic on,
		output int stalls);
		logic [31:0] rdata;
		logic        err;
		logic        bad;
		bad = !(op inside {DRAW_TILE, CLEAR_SCREEN}) || (r >= `ROOM_COUNT);
		apbTransfer(1'b1, `CMD_ADDR, commandWord(op, r, f, on), rdata, err, stalls);
		checkFlag({name, " pslverr"}, bad, err);
		if (!bad)
			modelCommand(op, r, f, on); // model follows every accepted command
	endtask

	task automatic waitIdle(string name);
		logic [31:0] rdata;
		logic        err;
		int          stalls;
		do
			apbTransfer(1'b0, `STATUS_ADDR, 32'b0, rdata, err, stalls);
		while (rdata[0] === 1'b1); // busy bit
		checkFlag({name, " status ready"}, 1'b0, stalls > 0);
	endtask

	task automatic checkPixel(string name, xCoord x, yCoord y);
		logic [31:0] rdata;
		logic        err;
		int          stalls;
		apbTransfer(1'b0, {1'b1, y, x}, 32'b0, rdata, err, stalls);
		nameQ.push_back($sformatf("%s (%0d,%0d)", name, x, y));
		expQ.push_back(expectedPixel(x, y));
		actQ.push_back(colourT'(rdata[`COLOUR_BITS-1:0]));
	endtask

	task automatic checkTileArea(string name, roomT r, functionT f);
		for (int j = -1; j <= `TILE_SIDE; j++) // tile plus a one pixel ring
			for (int i = -1; i <= `TILE_SIDE; i++)
				checkPixel(name, xCoord'(int'(tileX(r)) + i), yCoord'(int'(tileY(f)) + j));
	endtask

	task automatic checkRandomPixels(string name, int count);
		repeat (count)
			checkPixel(name, xCoord'($urandom_range(`SCREEN_WIDTH - 1)),
				yCoord'($urandom_range(`SCREEN_HEIGHT - 1)));
	endtask

	always @(posedge clock) begin // compares pixel reads against the model
		while (actQ.size() > 0)
			checkColour(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
	end

	initial begin
		#(LIMIT);
		$display("timeout after %0d time units, a transfer or engine never finished", LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int          stalls;
		roomT        r;
		functionT    f;
		logic [31:0] rdata;
		logic        err;
		void'($urandom(32'hf070));
		errors = 0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		foreach (model[i]) model[i] = BLACK;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		sendCommand("clear", CLEAR_SCREEN, 3'd0, DOOR, 1'b0, stalls); // whole screen black
		waitIdle("clear");
		checkRandomPixels("after clear", 200);

		repeat (8) begin // tiles switched on
			r = roomT'($urandom_range(`ROOM_COUNT - 1));
			f = functionT'($urandom_range(1));
			sendCommand("draw on", DRAW_TILE, r, f, 1'b1, stalls);
			waitIdle("draw on");
			checkTileArea("draw on", r, f);
		end

		repeat (4) begin // same tile switched off, other band untouched
			r = roomT'($urandom_range(`ROOM_COUNT - 1));
			f = functionT'($urandom_range(1));
			sendCommand("redraw on", DRAW_TILE, r, f, 1'b1, stalls);
			waitIdle("redraw on");
			sendCommand("redraw off", DRAW_TILE, r, f, 1'b0, stalls);
			waitIdle("redraw off");
			checkTileArea("redraw off", r, f);
			checkTileArea("other function", r, functionT'(~f));
		end

		sendCommand("bad room", DRAW_TILE, roomT'(5 + $urandom_range(2)), LIGHT, 1'b1, stalls);
		apbTransfer(1'b0, `STATUS_ADDR, 32'b0, rdata, err, stalls);
		checkFlag("busy after bad room", 1'b0, rdata[0]); // no drawer started
		sendCommand("nop", NOP, 3'd1, DOOR, 1'b1, stalls);
		sendCommand("opcode 3", opcodeT'(2'd3), 3'd2, LIGHT, 1'b1, stalls);
		apbTransfer(1'b0, `STATUS_ADDR, 32'b0, rdata, err, stalls);
		checkFlag("busy after rejects", 1'b0, rdata[0]);
		for (int i = 0; i < `ROOM_COUNT; i++) begin
			checkTileArea("after rejects", roomT'(i), LIGHT);
			checkTileArea("after rejects", roomT'(i), DOOR);
		end

		r = roomT'($urandom_range(`ROOM_COUNT - 1));
		f = functionT'($urandom_range(1));
		sendCommand("clear busy", CLEAR_SCREEN, 3'd0, DOOR, 1'b0, stalls);
		sendCommand("held draw", DRAW_TILE, r, f, 1'b1, stalls); // must wait for the sweep
		checkFlag("held draw stalled", 1'b1, stalls > 0);
		waitIdle("held draw");
		checkTileArea("held draw", r, f);
		checkRandomPixels("after held draw", 200);

		repeat (2) begin // reads queue behind the running drawer
			r = roomT'($urandom_range(`ROOM_COUNT - 1));
			f = functionT'($urandom_range(1));
			sendCommand("read during draw", DRAW_TILE, r, f, $urandom_range(1), stalls);
			checkTileArea("read during draw", r, f);
			waitIdle("read during draw");
		end

		repeat (2) @(posedge clock); // let the compare process drain
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- homeDisplay.f
+incdir+rtl
rtl/displayPkg.sv
rtl/controlPkg.sv
rtl/apbCommandRegs.sv
rtl/tileDrawer.sv
rtl/screenClearer.sv
rtl/pixelArbiter.sv
rtl/frameBuffer.sv
rtl/homeDisplay.sv
test/homeDisplay_sva.sv
test/homeDisplay_tb.sv
